//--- hdl/predecode_pkg.sv
//////////////////////////////
// Pre-decode shared types.
// Widths, branch encodings and the packets that
// move through the pre-decode branch predictor.
//////////////////////////////

package predecode_pkg;

// Address and instruction width.
localparam int ADDR_W = 32;

// Condition code for "always".
localparam logic [3:0] COND_AL = 4'b1110;

// Architectural register numbers.
localparam logic [3:0] REG_SP = 4'd13;
localparam logic [3:0] LR_NUM = 4'd14;
localparam logic [3:0] REG_PC = 4'd15;

// Two bit taken state from fetch. WT and ST mean predicted taken.
typedef enum logic [1:0]
{
        SNT = 2'd0,
        WNT = 2'd1,
        WT  = 2'd2,
        ST  = 2'd3
} taken_e;

// Data processing opcodes that can act as a jump.
typedef enum logic [3:0]
{
        OP_ADD = 4'b0100,
        OP_MOV = 4'b1101
} dp_opcode_e;

typedef enum logic [2:0]
{
        BR_NONE   = 3'd0,
        BR_CALL   = 3'd1,
        BR_RETURN = 3'd2,
        BR_TABLE  = 3'd3,
        BR_OTHER  = 3'd4
} branch_class_e;

typedef struct packed
{
        logic              valid;
        logic [ADDR_W-1:0] instr;
        logic [ADDR_W-1:0] pc;
        taken_e            taken;
        logic              pred_valid;
        logic [ADDR_W-1:0] pred_addr;
} fetch_pkt_t;

// Classifier result. Offset is already scaled to bytes.
typedef struct packed
{
        branch_class_e     cls;
        logic              cond_al;
        logic              link;
        logic [ADDR_W-1:0] offset;
} class_pkt_t;

typedef struct packed
{
        logic              valid;
        logic [ADDR_W-1:0] instr;
        logic [ADDR_W-1:0] pc;
        taken_e            taken;
        logic [ADDR_W-1:0] ppc;
} decode_pkt_t;

endpackage

//--- hdl/branch_classify.sv
//////////////////////////////
// Branch classifier.
// Sorts a fetched ARM instruction into a branch class
// and pulls out the condition, link bit and call offset.
//////////////////////////////

`timescale 1ns/1ns

module branch_classify
        import predecode_pkg::*;
(
        input  logic [ADDR_W-1:0] i_instr,
        input  logic              i_valid,
        output class_pkt_t        o_class
);

logic is_call;
logic is_bx_lr;
logic is_mov_pc_lr;
logic is_ldm_pc;
logic is_ldr_pc;
logic is_ldr_pc_sp;
logic is_dp_pc;

// Branch with optional link.
assign is_call = (i_instr[27:25] == 3'b101);

// BX LR.
assign is_bx_lr = (i_instr[27:4] == 24'h12fff1) &&
                  (i_instr[3:0] == LR_NUM);

// MOV PC, LR with no shift and no flag update.
assign is_mov_pc_lr = (i_instr[27:25] == 3'b000)    &&
                      (i_instr[24:21] == OP_MOV)    &&
                      !i_instr[20]                  &&
                      (i_instr[19:16] == 4'd0)      &&
                      (i_instr[15:12] == REG_PC)    &&
                      (i_instr[11:4] == 8'd0)       &&
                      (i_instr[3:0] == LR_NUM);

// Load multiple with PC in the register list.
assign is_ldm_pc = (i_instr[27:25] == 3'b100) && i_instr[20] && i_instr[15];

// Single load into PC. Register offset form needs bit 4 clear.
assign is_ldr_pc = (i_instr[27:26] == 2'b01)     &&
                   !(i_instr[25] && i_instr[4])  &&
                   i_instr[20]                   &&
                   (i_instr[15:12] == REG_PC);

assign is_ldr_pc_sp = is_ldr_pc && (i_instr[19:16] == REG_SP);

// ADD or MOV into PC. Multiply and extra load space is excluded.
assign is_dp_pc = (i_instr[27:26] == 2'b00)                       &&
                  (i_instr[15:12] == REG_PC)                      &&
                  (i_instr[25] || !i_instr[4] || !i_instr[7])     &&
                  ((i_instr[24:21] == OP_ADD) || (i_instr[24:21] == OP_MOV));

always_comb
begin
        o_class.cond_al = (i_instr[31:28] == COND_AL);
        o_class.link    = is_call && i_instr[24];

        // Word offset, sign extended and turned into bytes.
        o_class.offset  = {{6{i_instr[23]}}, i_instr[23:0], 2'b00};

        if (!i_valid)
        begin
                o_class.cls = BR_NONE;
        end
        else if (is_call)
        begin
                o_class.cls = BR_CALL;
        end
        else if (is_bx_lr || is_mov_pc_lr || is_ldm_pc || is_ldr_pc_sp)
        begin
                o_class.cls = BR_RETURN;
        end
        else if (is_ldr_pc || is_dp_pc)
        begin
                o_class.cls = BR_TABLE;
        end
        else
        begin
                o_class.cls = BR_OTHER;
        end
end

endmodule

//--- hdl/return_stack.sv
//////////////////////////////
// Return address stack.
// Circular stack of return addresses for call and
// return prediction. Overflow drops the oldest entry.
//////////////////////////////

`timescale 1ns/1ns

module return_stack
        import predecode_pkg::*;
#(
        parameter int unsigned RAS_DEPTH = 8
)
(
        input  logic              i_clk,
        input  logic              i_reset,
        input  logic              i_push,
        input  logic              i_pop,
        input  logic [ADDR_W-1:0] i_push_addr,
        output logic [ADDR_W-1:0] o_top
);

localparam int unsigned PTR_W = $clog2(RAS_DEPTH);

logic [RAS_DEPTH-1:0][ADDR_W-1:0] ras_ff;
logic [PTR_W-1:0]                 ptr_ff;
logic [PTR_W-1:0]                 ptr_below;

// Pointer always names the next free slot.
assign ptr_below = ptr_ff - PTR_W'(1);

// Most recent push sits just below the pointer.
assign o_top = ras_ff[ptr_below];

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                ras_ff <= '0;
                ptr_ff <= '0;
        end
        else if (i_push)
        begin
                ras_ff[ptr_ff] <= i_push_addr;
                ptr_ff         <= ptr_ff + PTR_W'(1);
        end
        else if (i_pop)
        begin
                // Entry stays in place, only the pointer moves.
                ptr_ff <= ptr_below;
        end
end

endmodule

//--- hdl/branch_predict.sv
//////////////////////////////
// Branch predictor.
// Predicts calls and returns, corrects the BTB and
// holds the registered pre-decode output.
//////////////////////////////

`timescale 1ns/1ns

module branch_predict
        import predecode_pkg::*;
(
        input  logic              i_clk,
        input  logic              i_reset,

        input  fetch_pkt_t        i_fetch,
        input  class_pkt_t        i_class,
        input  logic [ADDR_W-1:0] i_ras_top,

        // Highest priority first.
        input  logic              i_clear_from_writeback,
        input  logic              i_data_stall,
        input  logic              i_clear_from_alu,
        input  logic              i_stall_from_issue,

        output logic              o_push,
        output logic              o_pop,
        output logic [ADDR_W-1:0] o_push_addr,

        output decode_pkt_t       o_decode,
        output logic              o_clear_from_decode,
        output logic [ADDR_W-1:0] o_pc_from_decode,
        output logic              o_clear_btb
);

logic              advance;
logic              clear_stage;
logic              is_taken;
logic [ADDR_W-1:0] pc_plus_4;
logic [ADDR_W-1:0] call_target;
logic              push_nxt;
logic              pop_nxt;
logic              clear_nxt;
logic              clear_btb_nxt;
logic [ADDR_W-1:0] pc_from_decode_nxt;
logic [ADDR_W-1:0] ppc_nxt;
taken_e            taken_nxt;

// A slot advances only with no clear, no stall and no pending redirect.
assign advance = !i_clear_from_writeback && !i_data_stall && !i_clear_from_alu &&
                 !i_stall_from_issue && !o_clear_from_decode;

// Own redirect flushes the next slot that would have advanced.
assign clear_stage = i_clear_from_writeback ||
                     (!i_data_stall && (i_clear_from_alu ||
                      (!i_stall_from_issue && o_clear_from_decode)));

assign is_taken    = (i_fetch.taken == WT) || (i_fetch.taken == ST) || i_class.cond_al;
assign pc_plus_4   = i_fetch.pc + ADDR_W'(4);
assign call_target = i_fetch.pc + ADDR_W'(8) + i_class.offset;

// Stack is only touched on a slot that really moves on.
assign o_push      = push_nxt && advance;
assign o_pop       = pop_nxt && advance;
assign o_push_addr = pc_plus_4;

always_comb
begin
        push_nxt           = 1'b0;
        pop_nxt            = 1'b0;
        clear_nxt          = 1'b0;
        clear_btb_nxt      = 1'b0;
        pc_from_decode_nxt = '0;
        ppc_nxt            = o_decode.ppc;
        taken_nxt          = i_fetch.taken;

        case (i_class.cls)
        BR_CALL, BR_RETURN:
        begin
                if (is_taken)
                begin
                        if (i_class.cls == BR_CALL)
                        begin
                                pc_from_decode_nxt = call_target;
                                push_nxt           = i_class.link;
                        end
                        else
                        begin
                                pc_from_decode_nxt = i_ras_top;
                                pop_nxt            = 1'b1;
                        end

                        ppc_nxt   = pc_from_decode_nxt;
                        clear_nxt = !i_fetch.pred_valid ||
                                    (i_fetch.pred_addr != pc_from_decode_nxt);

                        if (i_class.cond_al)
                        begin
                                taken_nxt = ST;
                        end
                end
                else
                begin
                        ppc_nxt = pc_plus_4;
                end
        end
        BR_TABLE:
        begin
                // Trust the BTB for jump tables.
        end
        BR_OTHER:
        begin
                taken_nxt = SNT;

                // A BTB hit on a non-branch is stale, so drop it.
                if (i_fetch.pred_valid)
                begin
                        clear_nxt          = 1'b1;
                        clear_btb_nxt      = 1'b1;
                        pc_from_decode_nxt = pc_plus_4;
                        ppc_nxt            = pc_plus_4;
                end
        end
        default:
        begin
                taken_nxt = SNT;
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_decode.valid      <= 1'b0;
                o_decode.taken      <= SNT;
                o_decode.ppc        <= '0;
                o_clear_from_decode <= 1'b0;
                o_clear_btb         <= 1'b0;
        end
        else if (clear_stage)
        begin
                o_decode.valid      <= 1'b0;
                o_decode.taken      <= SNT;
                o_clear_from_decode <= 1'b0;
                o_clear_btb         <= 1'b0;
        end
        else if (advance)
        begin
                o_decode.valid      <= i_fetch.valid;
                o_decode.instr      <= i_fetch.instr;
                o_decode.pc         <= i_fetch.pc;
                o_decode.taken      <= taken_nxt;
                o_decode.ppc        <= ppc_nxt;
                o_clear_from_decode <= clear_nxt;
                o_pc_from_decode    <= pc_from_decode_nxt;
                o_clear_btb         <= clear_btb_nxt;
        end
end

endmodule

//--- hdl/predecode_top.sv
//////////////////////////////
// Pre-decode branch stage.
// Classifier, return stack and predictor joined into
// one stage with a single output register.
//////////////////////////////

`timescale 1ns/1ns

module predecode_top
        import predecode_pkg::*;
#(
        parameter int unsigned RAS_DEPTH = 8
)
(
        input  logic              i_clk,
        input  logic              i_reset,

        input  fetch_pkt_t        i_fetch,

        input  logic              i_clear_from_writeback,
        input  logic              i_data_stall,
        input  logic              i_clear_from_alu,
        input  logic              i_stall_from_issue,

        output decode_pkt_t       o_decode,
        output logic              o_clear_from_decode,
        output logic [ADDR_W-1:0] o_pc_from_decode,
        output logic              o_clear_btb
);

class_pkt_t        instr_class;
logic              ras_push;
logic              ras_pop;
logic [ADDR_W-1:0] ras_push_addr;
logic [ADDR_W-1:0] ras_top;

branch_classify u_branch_classify
(
        .i_instr (i_fetch.instr),
        .i_valid (i_fetch.valid),
        .o_class (instr_class)
);

return_stack
#(
        .RAS_DEPTH (RAS_DEPTH)
)
u_return_stack
(
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_push      (ras_push),
        .i_pop       (ras_pop),
        .i_push_addr (ras_push_addr),
        .o_top       (ras_top)
);

branch_predict u_branch_predict
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_fetch                (i_fetch),
        .i_class                (instr_class),
        .i_ras_top              (ras_top),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_issue     (i_stall_from_issue),
        .o_push                 (ras_push),
        .o_pop                  (ras_pop),
        .o_push_addr            (ras_push_addr),
        .o_decode               (o_decode),
        .o_clear_from_decode    (o_clear_from_decode),
        .o_pc_from_decode       (o_pc_from_decode),
        .o_clear_btb            (o_clear_btb)
);

endmodule

//--- testbench/predecode_tb_assert.sv
//////////////////////////////
// Pre-decode stage assertions.
// Control protocol properties bound into the stage.
//////////////////////////////

`timescale 1ns/1ns

module predecode_assert
        import predecode_pkg::*;
(
        input logic        i_clk,
        input logic        i_reset,
        input logic        i_clear_from_writeback,
        input logic        i_data_stall,
        input logic        i_stall_from_issue,
        input decode_pkt_t i_decode,
        input logic        i_clear_from_decode,
        input logic        i_clear_btb
);

int fail_cnt = 0;

// A redirect flushes the next slot that is not stalled.
redirect_flush: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear_from_decode && !i_data_stall && !i_stall_from_issue |=> !i_decode.valid)
else
begin
        $error("Slot after a decode redirect was not flushed.");
        fail_cnt++;
end

btb_clear_with_redirect: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear_btb |-> i_clear_from_decode)
else
begin
        $error("BTB clear raised without a decode redirect.");
        fail_cnt++;
end

// Writeback clear outranks the data stall.
data_stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        i_data_stall && !i_clear_from_writeback |=>
        $stable(i_decode) && $stable(i_clear_from_decode) && $stable(i_clear_btb))
else
begin
        $error("Stage outputs moved during a data stall.");
        fail_cnt++;
end

writeback_clear: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear_from_writeback |=> !i_decode.valid)
else
begin
        $error("Output stayed valid after a writeback clear.");
        fail_cnt++;
end

endmodule

bind predecode_top predecode_assert u_predecode_assert
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_decode               (o_decode),
        .i_clear_from_decode    (o_clear_from_decode),
        .i_clear_btb            (o_clear_btb)
);

//--- testbench/predecode_tb.sv
//////////////////////////////
// Pre-decode stage testbench.
// Directed and random stimulus against a reference
// model of the branch predictor and return stack.
//////////////////////////////

`timescale 1ns/1ns

module predecode_tb
        import predecode_pkg::*;
;

localparam int RAS_DEPTH   = 4;
localparam int RAND_CYCLES = 400;
localparam int TEST_CYCLES = 460;
localparam int TIMEOUT_NS  = TEST_CYCLES * 20 + 2000;

localparam logic [31:0] BX_LR     = 32'he12fff1e;
localparam logic [31:0] MOV_PC_LR = 32'he1a0f00e;
localparam logic [31:0] LDR_PC_R0 = 32'he590f000;

logic              i_clk = 1'b0;
logic              i_reset;
fetch_pkt_t        i_fetch;
logic              i_clear_from_writeback;
logic              i_data_stall;
logic              i_clear_from_alu;
logic              i_stall_from_issue;
decode_pkt_t       o_decode;
logic              o_clear_from_decode;
logic [ADDR_W-1:0] o_pc_from_decode;
logic              o_clear_btb;

// Class of the packet on i_fetch, as the stimulus built it.
branch_class_e     stim_cls;

logic [31:0]       lcg_state = 32'hcef6e4b8;
int                checks = 0;
int                errors = 0;

// Reference model state.
logic              model_live = 1'b0;
logic              exp_valid;
logic [31:0]       exp_instr;
logic [31:0]       exp_pc;
taken_e            exp_taken;
logic [31:0]       exp_ppc;
logic              exp_clear;
logic [31:0]       exp_pcfd;
logic              exp_clear_btb;
logic [31:0]       ref_stack [RAS_DEPTH];
logic [1:0]        ref_ptr;

predecode_top
#(
        .RAS_DEPTH (RAS_DEPTH)
)
i_predecode_top
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_fetch                (i_fetch),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_issue     (i_stall_from_issue),
        .o_decode               (o_decode),
        .o_clear_from_decode    (o_clear_from_decode),
        .o_pc_from_decode       (o_pc_from_decode),
        .o_clear_btb            (o_clear_btb)
);

always #10 i_clk = ~i_clk;

function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

function automatic logic [31:0] random_pc();
        logic [31:0] v;
        v = lcg_next();
        return {v[31:2], 2'b00};
endfunction

function automatic logic [31:0] call_word(input logic [3:0] cond, input logic link,
                                          input logic [31:0] f);
        return {cond, 3'b101, link, f[23:0]};
endfunction

// ADD with an immediate into r0..r7, never a branch.
function automatic logic [31:0] filler_word(input logic [31:0] f, input logic [3:0] cond);
        return {cond, 3'b001, 4'b0100, 1'b0, f[3:0], 1'b0, f[6:4], f[18:7]};
endfunction

// Branch target is pc+8 plus the word offset in bytes.
function automatic logic [31:0] call_target(input logic [31:0] pc, input logic [31:0] instr);
        return pc + 32'd8 + ({{8{instr[23]}}, instr[23:0]} << 2);
endfunction

task automatic compare(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
                $display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
                errors++;
        end
endtask

task automatic send_packet(input logic [31:0] instr, input logic [31:0] pc, input taken_e taken,
                           input logic pv, input logic [31:0] pa, input branch_class_e cls);
        @(posedge i_clk);
        i_fetch  <= '{1'b1, instr, pc, taken, pv, pa};
        stim_cls <= cls;
endtask

// A bubble after each packet absorbs the flush of a redirect.
task automatic send_with_gap(input logic [31:0] instr, input logic [31:0] pc,
                             input taken_e taken, input logic pv, input logic [31:0] pa,
                             input branch_class_e cls);
        send_packet(instr, pc, taken, pv, pa, cls);
        @(posedge i_clk);
        i_fetch  <= '0;
        stim_cls <= BR_NONE;
endtask

task automatic send_random();
        logic [31:0]   r;
        logic [31:0]   c;
        logic [31:0]   pc;
        logic [3:0]    cond;
        logic [31:0]   instr;
        branch_class_e cls;
        r     = lcg_next();
        c     = lcg_next();
        pc    = random_pc();
        cond  = r[28] ? COND_AL : 4'h0;
        cls   = BR_OTHER;
        instr = filler_word(lcg_next(), cond);
        case (r[31:29])
        3'd0, 3'd1:
        begin
                instr = call_word(cond, r[27], lcg_next());
                cls   = BR_CALL;
        end
        3'd2:
        begin
                instr = {cond, BX_LR[27:0]};
                cls   = BR_RETURN;
        end
        3'd3:
        begin
                instr = {cond, MOV_PC_LR[27:0]};
                cls   = BR_RETURN;
        end
        3'd4:
        begin
                instr = LDR_PC_R0;
                cls   = BR_TABLE;
        end
        default:
        begin
        end
        endcase
        @(posedge i_clk);
        i_fetch                <= '{r[29:28] != 2'b11, instr, pc, taken_e'(r[26:25]), r[24],
                                    random_pc()};
        stim_cls               <= (r[29:28] != 2'b11) ? cls : BR_NONE;
        i_clear_from_writeback <= (c[31:28] == 4'd0);
        i_data_stall           <= (c[27:25] == 3'd0);
        i_clear_from_alu       <= (c[24:21] == 4'd0);
        i_stall_from_issue     <= (c[20:18] == 3'd0);
endtask

// Model follows the control priority: writeback clear, data stall,
// ALU clear, issue stall, own redirect flush, then advance.
always @(posedge i_clk)
begin
        logic        taken_now;
        logic [31:0] seq_pc;
        logic [31:0] tgt;
        if (i_reset)
        begin
                model_live    = 1'b1;
                exp_valid     = 1'b0;
                exp_taken     = SNT;
                exp_ppc       = 32'd0;
                exp_clear     = 1'b0;
                exp_clear_btb = 1'b0;
                ref_ptr       = 2'd0;
                for (int k = 0; k < RAS_DEPTH; k++)
                        ref_stack[k] = 32'd0;
        end
        else if (i_clear_from_writeback || (!i_data_stall && (i_clear_from_alu ||
                 (!i_stall_from_issue && exp_clear))))
        begin
                exp_valid     = 1'b0;
                exp_taken     = SNT;
                exp_clear     = 1'b0;
                exp_clear_btb = 1'b0;
        end
        else if (!i_data_stall && !i_stall_from_issue)
        begin
                taken_now     = (i_fetch.taken == WT) || (i_fetch.taken == ST) ||
                                (i_fetch.instr[31:28] == COND_AL);
                seq_pc        = i_fetch.pc + 32'd4;
                exp_valid     = i_fetch.valid;
                exp_instr     = i_fetch.instr;
                exp_pc        = i_fetch.pc;
                exp_taken     = i_fetch.taken;
                exp_clear     = 1'b0;
                exp_clear_btb = 1'b0;
                if ((stim_cls == BR_CALL || stim_cls == BR_RETURN) && taken_now)
                begin
                        if (stim_cls == BR_CALL)
                        begin
                                tgt = call_target(i_fetch.pc, i_fetch.instr);
                                if (i_fetch.instr[24])
                                begin
                                        ref_stack[ref_ptr] = seq_pc;
                                        ref_ptr            = ref_ptr + 2'd1;
                                end
                        end
                        else
                        begin
                                ref_ptr = ref_ptr - 2'd1;
                                tgt     = ref_stack[ref_ptr];
                        end
                        exp_ppc   = tgt;
                        exp_pcfd  = tgt;
                        exp_clear = !i_fetch.pred_valid || (i_fetch.pred_addr != tgt);
                        if (i_fetch.instr[31:28] == COND_AL)
                                exp_taken = ST;
                end
                else if (stim_cls == BR_CALL || stim_cls == BR_RETURN)
                        exp_ppc = seq_pc;
                else if (stim_cls == BR_OTHER || stim_cls == BR_NONE)
                begin
                        exp_taken = SNT;
                        if (stim_cls == BR_OTHER && i_fetch.pred_valid)
                        begin
                                exp_clear     = 1'b1;
                                exp_clear_btb = 1'b1;
                                exp_pcfd      = seq_pc;
                                exp_ppc       = seq_pc;
                        end
                end
        end
end

// Outputs are settled by the falling edge.
always @(negedge i_clk)
begin
        if (model_live)
        begin
                compare("o_decode.valid", 32'(exp_valid), 32'(o_decode.valid));
                compare("o_decode.taken", 32'(exp_taken), 32'(o_decode.taken));
                compare("o_decode.ppc", exp_ppc, o_decode.ppc);
                compare("o_clear_from_decode", 32'(exp_clear), 32'(o_clear_from_decode));
                compare("o_clear_btb", 32'(exp_clear_btb), 32'(o_clear_btb));
                if (exp_valid)
                begin
                        compare("o_decode.instr", exp_instr, o_decode.instr);
                        compare("o_decode.pc", exp_pc, o_decode.pc);
                end
                if (exp_clear)
                        compare("o_pc_from_decode", exp_pcfd, o_pc_from_decode);
        end
end

initial
begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns without the test finishing.", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
end

initial
begin
        logic [31:0] pc;
        logic [31:0] instr;
        int          assert_fails;
        i_reset                = 1'b1;
        i_fetch                = '0;
        stim_cls               = BR_NONE;
        i_clear_from_writeback = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_alu       = 1'b0;
        i_stall_from_issue     = 1'b0;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        // Unlinked call, first without and then with a matching prediction.
        pc    = random_pc();
        instr = call_word(COND_AL, 1'b0, lcg_next());
        send_with_gap(instr, pc, SNT, 1'b0, 32'd0, BR_CALL);
        send_with_gap(instr, pc, WT, 1'b1, call_target(pc, instr), BR_CALL);

        // Nested linked calls, deeper than the stack, then returns.
        for (int k = 0; k < 6; k++)
                send_with_gap(call_word(COND_AL, 1'b1, lcg_next()), random_pc(), WT, 1'b0,
                              32'd0, BR_CALL);
        for (int k = 0; k < 6; k++)
                send_with_gap(k[0] ? MOV_PC_LR : BX_LR, random_pc(), SNT, 1'b0, 32'd0,
                              BR_RETURN);

        // Not-taken conditional call between a call and its return.
        send_with_gap(call_word(COND_AL, 1'b1, lcg_next()), random_pc(), ST, 1'b0, 32'd0,
                      BR_CALL);
        send_with_gap(call_word(4'h0, 1'b1, lcg_next()), random_pc(), WNT, 1'b0, 32'd0,
                      BR_CALL);
        send_with_gap(BX_LR, random_pc(), ST, 1'b0, 32'd0, BR_RETURN);

        // Non-branch with and without a stale BTB hit.
        send_with_gap(filler_word(lcg_next(), COND_AL), random_pc(), WT, 1'b1, random_pc(),
                      BR_OTHER);
        send_with_gap(filler_word(lcg_next(), COND_AL), random_pc(), ST, 1'b0, 32'd0,
                      BR_OTHER);

        for (int n = 0; n < RAND_CYCLES; n++)
                send_random();
        @(posedge i_clk);
        i_fetch                <= '0;
        stim_cls               <= BR_NONE;
        i_clear_from_writeback <= 1'b0;
        i_data_stall           <= 1'b0;
        i_clear_from_alu       <= 1'b0;
        i_stall_from_issue     <= 1'b0;
        repeat (3) @(posedge i_clk);

        assert_fails = i_predecode_top.u_predecode_assert.fail_cnt;
        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
                $display("Simulation PASSED");
        else
                $display("Simulation FAILED");
        $finish;
end

endmodule

//--- verilog.f
hdl/predecode_pkg.sv
hdl/branch_classify.sv
hdl/return_stack.sv
hdl/branch_predict.sv
hdl/predecode_top.sv
testbench/predecode_tb_assert.sv
testbench/predecode_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= predecode_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
